// ==== hdl/thumb_expand_pkg.sv ====
// Shared types, opcodes and match patterns for the compressed-instruction expander; import with ::*
package thumb_expand_pkg;

        //////////////////////////////
        // Widths
        //////////////////////////////

        localparam int HWORD_W = 16;    // Compressed instruction
        localparam int ARM_W   = 32;    // Wide instruction body
        localparam int EXT_W   = 3;     // Extension field on top

        typedef logic [HWORD_W-1:0]       thumb_hword_t;
        typedef logic [ARM_W-1:0]         fetch_word_t;
        typedef logic [EXT_W+ARM_W-1:0]   arm_instr_t;  // {ext, 32-bit instr}
        typedef logic [3:0]               arm_reg_t;
        typedef logic [3:0]               arm_cond_t;
        typedef logic [3:0]               arm_dp_op_t;
        typedef logic [1:0]               arm_shift_t;

        //////////////////////////////
        // Wide-format field values
        //////////////////////////////

        localparam arm_cond_t COND_AL = 4'b1110;  // Always

        // Data-processing opcodes, bits 24..21
        localparam arm_dp_op_t OP_AND = 4'h0;
        localparam arm_dp_op_t OP_EOR = 4'h1;
        localparam arm_dp_op_t OP_SUB = 4'h2;
        localparam arm_dp_op_t OP_RSB = 4'h3;
        localparam arm_dp_op_t OP_ADD = 4'h4;
        localparam arm_dp_op_t OP_ADC = 4'h5;
        localparam arm_dp_op_t OP_SBC = 4'h6;
        localparam arm_dp_op_t OP_TST = 4'h8;
        localparam arm_dp_op_t OP_CMP = 4'hA;
        localparam arm_dp_op_t OP_CMN = 4'hB;
        localparam arm_dp_op_t OP_ORR = 4'hC;
        localparam arm_dp_op_t OP_MOV = 4'hD;
        localparam arm_dp_op_t OP_BIC = 4'hE;
        localparam arm_dp_op_t OP_MVN = 4'hF;

        localparam arm_shift_t SH_LSL = 2'd0;
        localparam arm_shift_t SH_LSR = 2'd1;
        localparam arm_shift_t SH_ASR = 2'd2;
        localparam arm_shift_t SH_ROR = 2'd3;

        localparam arm_reg_t REG_SP = 4'd13;    // Stack pointer

        // Top bit set -> branch offset counts halfwords
        localparam logic [EXT_W-1:0] EXT_HALF_OFFSET = 3'b100;

        // Fixed wide words, condition already AL
        localparam logic [ARM_W-1:0] ARM_BKPT     = 32'hE120_0070;
        localparam logic [ARM_W-1:0] ARM_BX_BASE  = 32'hE12F_FF10;  // Rm in [3:0]
        localparam logic [ARM_W-1:0] ARM_SWI_BASE = 32'hEF00_0000;  // Comment in [7:0]

        //////////////////////////////
        // Halfword match patterns
        //////////////////////////////

        // Several overlap; the matcher tests them by priority
        localparam thumb_hword_t PAT_SWI           = 16'b1101_1111_????_????;
        localparam thumb_hword_t PAT_ADD_SUB_LO    = 16'b0001_1???_????_????;
        localparam thumb_hword_t PAT_BX            = 16'b0100_0111_0???_????;
        localparam thumb_hword_t PAT_BKPT          = 16'b1011_1110_????_????;
        localparam thumb_hword_t PAT_BRANCH_COND   = 16'b1101_????_????_????;
        localparam thumb_hword_t PAT_BRANCH_NOCOND = 16'b1110_0???_????_????;
        localparam thumb_hword_t PAT_SHIFT         = 16'b000?_????_????_????;
        localparam thumb_hword_t PAT_MCAS_IMM      = 16'b001?_????_????_????;
        localparam thumb_hword_t PAT_ALU_LO        = 16'b0100_00??_????_????;
        localparam thumb_hword_t PAT_ALU_HI        = 16'b0100_01??_????_????;

        // Kept instruction classes
        typedef enum logic [3:0]
        {
                CLS_NONE,
                CLS_SHIFT,
                CLS_ADD_SUB_LO,
                CLS_MCAS_IMM,
                CLS_ALU_LO,
                CLS_ALU_HI,
                CLS_BRANCH_COND,
                CLS_BRANCH_NOCOND,
                CLS_SWI,
                CLS_BX,
                CLS_BKPT
        } thumb_class_t;

endpackage

// ==== hdl/thumb_class_match.sv ====
// Priority pattern matcher, sorts a halfword into one kept class; purely combinational
`timescale 1ns/1ps

module thumb_class_match
        import thumb_expand_pkg::*;
(
        input  thumb_hword_t    i_hword,        // Lower halfword of fetch
        output thumb_class_t    o_class         // CLS_NONE if not kept
);

//////////////////////////////
// Classification
//////////////////////////////

always_comb
begin
        o_class = CLS_NONE;

        // Overlapping encodings first
        // SWI sits inside the cond-branch space (cond 1111)
        if (i_hword ==? PAT_SWI)
        begin
                o_class = CLS_SWI;
        end
        else if (i_hword ==? PAT_ADD_SUB_LO)    // Inside shift space
        begin
                o_class = CLS_ADD_SUB_LO;
        end
        else if (i_hword ==? PAT_BX)            // Inside high ALU, op 3
        begin
                o_class = CLS_BX;
        end
        else if (i_hword ==? PAT_BKPT)
        begin
                o_class = CLS_BKPT;
        end
        else
        begin
                // Remaining patterns are disjoint
                casez (i_hword)
                        PAT_BRANCH_COND   : o_class = CLS_BRANCH_COND;
                        PAT_BRANCH_NOCOND : o_class = CLS_BRANCH_NOCOND;
                        PAT_SHIFT         : o_class = CLS_SHIFT;
                        PAT_MCAS_IMM      : o_class = CLS_MCAS_IMM;
                        PAT_ALU_LO        : o_class = CLS_ALU_LO;
                        PAT_ALU_HI        : o_class = CLS_ALU_HI;
                        default           : o_class = CLS_NONE;  // Loads, stores, BL...
                endcase
        end
end

//////////////////////////////
// Checks
//////////////////////////////

// A known halfword must always land on a known class
a_class_known: assert final ($isunknown(i_hword) || !$isunknown(o_class))
        else $error("class unknown for halfword %h", i_hword);

endmodule

// ==== hdl/thumb_dp_expand.sv ====
// Expands the five compressed data-processing classes into wide data-processing words
`timescale 1ns/1ps

module thumb_dp_expand
        import thumb_expand_pkg::*;
(
        input  thumb_hword_t    i_hword,
        input  thumb_class_t    i_class,
        output arm_instr_t      o_instr,        // Extension always 0 here
        output logic            o_hit           // One of our classes
);

// Wide data-processing word, condition AL
function automatic logic [ARM_W-1:0] dp_word
(
        input logic             imm,
        input arm_dp_op_t       op,
        input logic             s,
        input arm_reg_t         rn,
        input arm_reg_t         rd,
        input logic [11:0]      op2
);
        dp_word = {COND_AL, 2'b00, imm, op, s, rn, rd, op2};
endfunction

// Low register fields, zero-extended to 4 bits
arm_reg_t       rd_lo;          // [2:0]
arm_reg_t       rs_lo;          // [5:3]
arm_reg_t       rn_lo;          // [8:6], register or imm3
arm_reg_t       rd_mc;          // [10:8] for MOV/CMP/ADD/SUB imm
arm_reg_t       rd_hi;          // H1:[2:0]
arm_reg_t       rs_hi;          // H2:[5:3]
arm_dp_op_t     mcas_op;
logic [ARM_W-1:0] body;

assign rd_lo = {1'b0, i_hword[2:0]};
assign rs_lo = {1'b0, i_hword[5:3]};
assign rn_lo = {1'b0, i_hword[8:6]};
assign rd_mc = {1'b0, i_hword[10:8]};
assign rd_hi = {i_hword[7], i_hword[2:0]};
assign rs_hi = {i_hword[6], i_hword[5:3]};

// MOV, CMP, ADD, SUB by bits 12..11
always_comb
begin
        case (i_hword[12:11])
                2'd0:    mcas_op = OP_MOV;
                2'd1:    mcas_op = OP_CMP;
                2'd2:    mcas_op = OP_ADD;
                default: mcas_op = OP_SUB;
        endcase
end

//////////////////////////////
// Expansion
//////////////////////////////

always_comb
begin
        body = '0;
        case (i_class)
        CLS_SHIFT:      // MOVS Rd, Rs, <type> #amount
                body = dp_word(1'b0, OP_MOV, 1'b1, 4'd0, rd_lo,
                               {i_hword[10:6], i_hword[12:11], 1'b0, rs_lo});
        CLS_ADD_SUB_LO:
        begin
                // Bit 9 picks SUB, bit 10 picks imm3
                if (i_hword[10])
                        body = dp_word(1'b1, i_hword[9] ? OP_SUB : OP_ADD, 1'b1,
                                       rs_lo, rd_lo, {8'd0, rn_lo});
                else
                        body = dp_word(1'b0, i_hword[9] ? OP_SUB : OP_ADD, 1'b1,
                                       rs_lo, rd_lo, {8'd0, rn_lo});
        end
        CLS_MCAS_IMM:   // Flags always set
                body = dp_word(1'b1, mcas_op, 1'b1, rd_mc, rd_mc, {4'd0, i_hword[7:0]});
        CLS_ALU_LO:
        begin
                case (i_hword[9:6])
                4'd0:  body = dp_word(1'b0, OP_AND, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd1:  body = dp_word(1'b0, OP_EOR, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                // Register-specified shifts, Rs in [11:8]
                4'd2:  body = dp_word(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                      {rs_lo, 1'b0, SH_LSL, 1'b1, rd_lo});
                4'd3:  body = dp_word(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                      {rs_lo, 1'b0, SH_LSR, 1'b1, rd_lo});
                4'd4:  body = dp_word(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                      {rs_lo, 1'b0, SH_ASR, 1'b1, rd_lo});
                4'd5:  body = dp_word(1'b0, OP_ADC, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd6:  body = dp_word(1'b0, OP_SBC, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd7:  body = dp_word(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                      {rs_lo, 1'b0, SH_ROR, 1'b1, rd_lo});
                4'd8:  body = dp_word(1'b0, OP_TST, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd9:  body = dp_word(1'b1, OP_RSB, 1'b1, rs_lo, rd_lo, 12'd0); // NEG
                4'd10: body = dp_word(1'b0, OP_CMP, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd11: body = dp_word(1'b0, OP_CMN, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd12: body = dp_word(1'b0, OP_ORR, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd13: body = {COND_AL, 7'b0000000, 1'b1, rd_lo, 4'd0, rd_lo,
                               4'b1001, rs_lo};                          // MULS Rd = Rs * Rd
                4'd14: body = dp_word(1'b0, OP_BIC, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                default:
                       body = dp_word(1'b0, OP_MVN, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                endcase
        end
        CLS_ALU_HI:
        begin
                // Only CMP touches flags
                case (i_hword[9:8])
                2'd0:    body = dp_word(1'b0, OP_ADD, 1'b0, rd_hi, rd_hi, {8'd0, rs_hi});
                2'd1:    body = dp_word(1'b0, OP_CMP, 1'b1, rd_hi, rd_hi, {8'd0, rs_hi});
                2'd2:    body = dp_word(1'b0, OP_MOV, 1'b0, rd_hi, rd_hi, {8'd0, rs_hi});
                default: body = '0;     // Op 3 outside BX gives nothing
                endcase
        end
        default: body = '0;
        endcase
end

assign o_instr = {{EXT_W{1'b0}}, body};
assign o_hit   = i_class inside {CLS_SHIFT, CLS_ADD_SUB_LO, CLS_MCAS_IMM,
                                 CLS_ALU_LO, CLS_ALU_HI};

endmodule

// ==== hdl/thumb_flow_expand.sv ====
// Expands compressed branch, SWI, BX and BKPT classes into wide flow-control words
`timescale 1ns/1ps

module thumb_flow_expand
        import thumb_expand_pkg::*;
(
        input  thumb_hword_t    i_hword,
        input  thumb_class_t    i_class,
        output arm_instr_t      o_instr,
        output logic            o_hit
);

logic [23:0]    off8_sx;        // Cond branch offset, sign-extended
logic [23:0]    off11_sx;       // Uncond branch offset, sign-extended
arm_cond_t      br_cond;

assign off8_sx  = {{16{i_hword[7]}}, i_hword[7:0]};
assign off11_sx = {{13{i_hword[10]}}, i_hword[10:0]};
assign br_cond  = i_hword[11:8];

//////////////////////////////
// Expansion
//////////////////////////////

always_comb
begin
        o_instr = '0;
        case (i_class)
        CLS_BRANCH_COND:
                // B<cond>, offset left in halfwords
                o_instr = {EXT_HALF_OFFSET, br_cond, 3'b101, 1'b0, off8_sx};
        CLS_BRANCH_NOCOND:
                // Offset also in halfwords, so same extension
                o_instr = {EXT_HALF_OFFSET, COND_AL, 3'b101, 1'b0, off11_sx};
        CLS_SWI:
        begin
                o_instr            = {{EXT_W{1'b0}}, ARM_SWI_BASE};
                o_instr[7:0]       = i_hword[7:0];      // Comment byte
        end
        CLS_BX:
        begin
                o_instr            = {{EXT_W{1'b0}}, ARM_BX_BASE};
                o_instr[3:0]       = i_hword[6:3];      // H2:Rm, may be high reg
        end
        CLS_BKPT:
                o_instr = {{EXT_W{1'b0}}, ARM_BKPT};
        default:
                o_instr = '0;
        endcase
end

assign o_hit = i_class inside {CLS_BRANCH_COND, CLS_BRANCH_NOCOND, CLS_SWI,
                               CLS_BX, CLS_BKPT};

endmodule

// ==== hdl/thumb_decode_stage.sv ====
// Output stage, picks passthrough or expanded word and registers it with valid and undefined
`timescale 1ns/1ps

module thumb_decode_stage
        import thumb_expand_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_arst_n,
        input  fetch_word_t     i_instruction,
        input  logic            i_instruction_valid,
        input  logic            i_cpsr_ff_t,            // T-state
        input  arm_instr_t      i_dp_instr,
        input  arm_instr_t      i_flow_instr,
        input  logic            i_dp_hit,
        input  logic            i_flow_hit,
        output arm_instr_t      o_instruction,
        output logic            o_instruction_valid,
        output logic            o_und
);

arm_instr_t     sel_instr;
logic           sel_und;

always_comb
begin
        sel_instr = {{EXT_W{1'b0}}, i_instruction};     // Not T-state, pass through
        sel_und   = 1'b0;
        if (i_cpsr_ff_t)
        begin
                if (i_dp_hit)
                        sel_instr = i_dp_instr;
                else if (i_flow_hit)
                        sel_instr = i_flow_instr;
                else
                begin
                        sel_instr = '0;
                        sel_und   = i_instruction_valid;  // Trap only real items
                end
        end
end

//////////////////////////////
// Register stage
//////////////////////////////

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                o_instruction       <= '0;
                o_instruction_valid <= 1'b0;
                o_und               <= 1'b0;
        end
        else
        begin
                o_instruction       <= sel_instr;       // Loaded even when invalid
                o_instruction_valid <= i_instruction_valid;
                o_und               <= sel_und;
        end
end

// Class spaces of the two expanders must not overlap
a_one_hit: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_dp_hit && i_flow_hit))
        else $error("both expanders claim the halfword");

a_und_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_und |-> o_instruction_valid)
        else $error("undefined flag without valid");

endmodule

// ==== hdl/thumb_expand_top.sv ====
// Top level of the expander, one-cycle decoder stage between fetch and the wide decoder
`timescale 1ns/1ps

module thumb_expand_top
        import thumb_expand_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_arst_n,

        // From fetch
        input  fetch_word_t     i_instruction,
        input  logic            i_instruction_valid,
        input  logic            i_cpsr_ff_t,            // T bit of CPSR

        // To the wide decoder, one cycle later
        output arm_instr_t      o_instruction,
        output logic            o_instruction_valid,
        output logic            o_und
);

thumb_class_t   hw_class;
arm_instr_t     dp_instr;
arm_instr_t     flow_instr;
logic           dp_hit;
logic           flow_hit;

//////////////////////////////
// Combinational front
//////////////////////////////

thumb_class_match u_class_match
(
        .i_hword        (i_instruction[HWORD_W-1:0]),
        .o_class        (hw_class)
);

thumb_dp_expand u_dp_expand
(
        .i_hword        (i_instruction[HWORD_W-1:0]),
        .i_class        (hw_class),
        .o_instr        (dp_instr),
        .o_hit          (dp_hit)
);

thumb_flow_expand u_flow_expand
(
        .i_hword        (i_instruction[HWORD_W-1:0]),
        .i_class        (hw_class),
        .o_instr        (flow_instr),
        .o_hit          (flow_hit)
);

//////////////////////////////
// Registered output
//////////////////////////////

thumb_decode_stage u_decode_stage
(
        .i_clk                  (i_clk),
        .i_arst_n               (i_arst_n),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .i_dp_instr             (dp_instr),
        .i_flow_instr           (flow_instr),
        .i_dp_hit               (dp_hit),
        .i_flow_hit             (flow_hit),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und)
);

endmodule

// ==== bench/thumb_expand_vectors.svh ====
// Stimulus and expected-value table for the expander testbench; included inside the testbench module
`ifndef THUMB_EXPAND_VECTORS_SVH
`define THUMB_EXPAND_VECTORS_SVH

localparam int NUM_VEC = 23;

// Columns: fetch word, T bit, valid, expected wide word {ext, instr}, expected undefined
fetch_word_t    vec_word  [NUM_VEC];
logic           vec_t     [NUM_VEC];
logic           vec_valid [NUM_VEC];
arm_instr_t     vec_exp   [NUM_VEC];
logic           vec_und   [NUM_VEC];
int             vec_cnt;                // Rows loaded so far

// Appends one row
task automatic add_vec
(
        input fetch_word_t      word,
        input logic             t_bit,
        input logic             valid,
        input arm_instr_t       exp_instr,
        input logic             exp_und
);
        vec_word[vec_cnt]  = word;
        vec_t[vec_cnt]     = t_bit;
        vec_valid[vec_cnt] = valid;
        vec_exp[vec_cnt]   = exp_instr;
        vec_und[vec_cnt]   = exp_und;
        vec_cnt++;
endtask

//////////////////////////////
// Table rows
//////////////////////////////

task automatic load_vectors;
        vec_cnt = 0;
        // Data processing
        add_vec(32'h0000_0951, 1'b1, 1'b1, 35'h0_E1B0_12A2, 1'b0);  // LSRS r1, r2, #5
        add_vec(32'h0000_18D1, 1'b1, 1'b1, 35'h0_E092_1003, 1'b0);  // ADDS r1, r2, r3
        add_vec(32'h0000_1AD1, 1'b1, 1'b1, 35'h0_E052_1003, 1'b0);  // SUBS r1, r2, r3
        add_vec(32'h0000_1D67, 1'b1, 1'b1, 35'h0_E294_7005, 1'b0);  // ADDS r7, r4, #5
        add_vec(32'h0000_1FC3, 1'b1, 1'b1, 35'h0_E250_3007, 1'b0);  // SUBS r3, r0, #7
        add_vec(32'h0000_2D7F, 1'b1, 1'b1, 35'h0_E355_507F, 1'b0);  // CMP r5, #0x7F
        add_vec(32'h0000_22C4, 1'b1, 1'b1, 35'h0_E3B2_20C4, 1'b0);  // MOVS r2, #0xC4
        add_vec(32'h0000_4074, 1'b1, 1'b1, 35'h0_E034_4006, 1'b0);  // EORS r4, r6
        add_vec(32'h0000_411A, 1'b1, 1'b1, 35'h0_E1B2_2352, 1'b0);  // ASRS r2, r3
        add_vec(32'h0000_4269, 1'b1, 1'b1, 35'h0_E275_1000, 1'b0);  // NEGS r1, r5
        add_vec(32'h0000_4378, 1'b1, 1'b1, 35'h0_E010_0097, 1'b0);  // MULS r0, r7
        add_vec(32'h0000_46AB, 1'b1, 1'b1, 35'h0_E1AB_B005, 1'b0);  // MOV r11, r5
        add_vec(32'h0000_4562, 1'b1, 1'b1, 35'h0_E152_200C, 1'b0);  // CMP r2, r12
        // Flow control, branches keep halfword offsets
        add_vec(32'h0000_D1FC, 1'b1, 1'b1, 35'h4_1AFF_FFFC, 1'b0);  // BNE -4
        add_vec(32'h0000_E123, 1'b1, 1'b1, 35'h4_EA00_0123, 1'b0);  // B +0x123
        add_vec(32'h0000_DF5A, 1'b1, 1'b1, 35'h0_EF00_005A, 1'b0);  // SWI 0x5A
        add_vec(32'h0000_4770, 1'b1, 1'b1, 35'h0_E12F_FF1E, 1'b0);  // BX lr
        add_vec(32'h0000_BE01, 1'b1, 1'b1, 35'h0_E120_0070, 1'b0);  // BKPT
        // Undefined in T-state
        add_vec(32'h0000_6808, 1'b1, 1'b1, 35'h0_0000_0000, 1'b1);  // LDR, trapped
        add_vec(32'h0000_6808, 1'b1, 1'b0, 35'h0_0000_0000, 1'b0);  // Same, not valid
        add_vec(32'h0000_F000, 1'b1, 1'b1, 35'h0_0000_0000, 1'b1);  // BL prefix
        // Passthrough, then upper half ignored in T-state
        add_vec(32'h1234_4770, 1'b0, 1'b1, 35'h0_1234_4770, 1'b0);
        add_vec(32'hFFFF_0951, 1'b1, 1'b1, 35'h0_E1B0_12A2, 1'b0);
endtask

`endif

// ==== bench/tb_thumb_expand.sv ====
// Testbench for the expander top level, runs the vector table and a random passthrough burst
`timescale 1ns/1ps

module tb_thumb_expand
        import thumb_expand_pkg::*;
();

localparam int CLK_HALF    = 4;         // 8 ns period
localparam int NUM_RAND    = 32;

logic           i_clk;
logic           i_arst_n;
fetch_word_t    i_instruction;
logic           i_instruction_valid;
logic           i_cpsr_ff_t;
arm_instr_t     o_instruction;
logic           o_instruction_valid;
logic           o_und;

fetch_word_t    rand_word [NUM_RAND];   // Passthrough stimulus
integer         seed;

`include "thumb_expand_vectors.svh"

localparam int WATCHDOG_NS = (NUM_VEC + NUM_RAND + 20) * 2 * CLK_HALF;

thumb_expand_top UUT
(
        .i_clk                  (i_clk),
        .i_arst_n               (i_arst_n),
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_und                  (o_und)
);

initial i_clk = 1'b0;
always #(CLK_HALF) i_clk = ~i_clk;

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_instr(input string name, input arm_instr_t exp, input arm_instr_t act);
        if (act !== exp)
        begin
                $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
                $display("SIMULATION FAILED");
                $fatal(1, "wide word mismatch");
        end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
                $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
                $display("SIMULATION FAILED");
                $fatal(1, "flag mismatch");
        end
endtask

// Word only matters for valid items
task automatic check_result(input arm_instr_t exp_instr, input logic exp_valid,
                            input logic exp_und);
        check_flag("o_instruction_valid", exp_valid, o_instruction_valid);
        check_flag("o_und", exp_und, o_und);
        if (exp_valid)
                check_instr("o_instruction", exp_instr, o_instruction);
endtask

//////////////////////////////
// Main sequence
//////////////////////////////

initial
begin
        i_arst_n            = 1'b0;
        i_instruction       = '0;
        i_instruction_valid = 1'b0;
        i_cpsr_ff_t         = 1'b0;
        seed                = 32'hb9da;
        load_vectors();
        if (vec_cnt != NUM_VEC)
        begin
                $display("Vector table holds %0d rows instead of %0d", vec_cnt, NUM_VEC);
                $display("SIMULATION FAILED");
                $fatal(1, "bad table");
        end
        for (int i = 0; i < NUM_RAND; i++)
                rand_word[i] = $random(seed);

        // Reset low for 4 cycles, outputs cleared meanwhile
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        check_instr("o_instruction", '0, o_instruction);
        check_result('0, 1'b0, 1'b0);
        @(posedge i_clk);
        i_arst_n <= 1'b1;

        // Idle after reset, nothing valid yet
        repeat (2)
        begin
                @(posedge i_clk);
                @(negedge i_clk);
                check_result('0, 1'b0, 1'b0);
        end

        // Table back to back, result one cycle behind its row
        for (int i = 0; i <= NUM_VEC; i++)
        begin
                @(posedge i_clk);
                if (i < NUM_VEC)
                begin
                        i_instruction       <= vec_word[i];
                        i_cpsr_ff_t         <= vec_t[i];
                        i_instruction_valid <= vec_valid[i];
                end
                else
                        i_instruction_valid <= 1'b0;   // Drain
                @(negedge i_clk);
                if (i > 0)
                        check_result(vec_exp[i-1], vec_valid[i-1], vec_und[i-1]);
        end

        // Random words with T clear, zero-extended out
        for (int i = 0; i <= NUM_RAND; i++)
        begin
                @(posedge i_clk);
                if (i < NUM_RAND)
                begin
                        i_instruction       <= rand_word[i];
                        i_cpsr_ff_t         <= 1'b0;
                        i_instruction_valid <= 1'b1;
                end
                else
                        i_instruction_valid <= 1'b0;
                @(negedge i_clk);
                if (i > 0)
                        check_result({3'b000, rand_word[i-1]}, 1'b1, 1'b0);
        end

        $display("SIMULATION PASSED");
        $finish;
end

// Watchdog, sized from table and random run lengths
initial
begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
end

endmodule

// ==== thumb_expand.f ====
+incdir+bench
hdl/thumb_expand_pkg.sv
hdl/thumb_class_match.sv
hdl/thumb_dp_expand.sv
hdl/thumb_flow_expand.sv
hdl/thumb_decode_stage.sv
hdl/thumb_expand_top.sv
bench/tb_thumb_expand.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the expander testbench with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf "$OBJ"

verilator --binary --timing --assert --top-module tb_thumb_expand \
        -Mdir "$OBJ" -f thumb_expand.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
        echo "Build failed with status $status, see $BUILD_LOG"
        exit 1
fi

"./$OBJ/Vtb_thumb_expand" > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status, see $SIM_LOG"
        exit 1
fi

if grep -q "SIMULATION PASSED" "$SIM_LOG"; then
        echo "Test passed"
        exit 0
else
        echo "Pass line missing, see $SIM_LOG"
        exit 1
fi
